// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Register data width.
`define CORE_DATA_WIDTH 32

// Register index width.
`define CORE_REG_ADDR_WIDTH 5

// Shift amount width.
`define CORE_SHAMT_WIDTH 5

// Multiply latency in stages.
`define CORE_MUL_STAGES 5

`endif

// File: source/isa_pkg.sv
`default_nettype none
`include "core_defines.svh"

package isa_pkg;

  typedef enum logic [6:0] {
    R         = 7'b0110011,
    IMMEDIATE = 7'b0010011,
    LOAD      = 7'b0000011,
    STORE     = 7'b0100011,
    BRANCH    = 7'b1100011,
    JAL       = 7'b1101111,
    AUIPC     = 7'b0010111
  } opcode_e;

  typedef struct packed {
    logic [6:0]                     funct7;
    logic [`CORE_REG_ADDR_WIDTH-1:0] rs2;
    logic [`CORE_REG_ADDR_WIDTH-1:0] rs1;
    logic [2:0]                     funct3;
    logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
    opcode_e                        opcode;
  } instruction_t;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SLT = 4'd5,
    ALU_SLL = 4'd6,
    ALU_SRL = 4'd7
  } alu_op_e;

endpackage : isa_pkg

`default_nettype wire

// File: source/pipe_pkg.sv
`default_nettype none
`include "core_defines.svh"

package pipe_pkg;

  // Source usage of the instruction in decode.
  typedef struct packed {
    logic [`CORE_REG_ADDR_WIDTH-1:0] rs1;
    logic [`CORE_REG_ADDR_WIDTH-1:0] rs2;
    logic                           rs1_needed;
    logic                           rs2_needed;
    logic                           is_mul;
  } hazard_ctrl_t;

  typedef struct packed {
    isa_pkg::alu_op_e               alu_op;
    logic [`CORE_DATA_WIDTH-1:0]     operand_a;
    logic [`CORE_DATA_WIDTH-1:0]     operand_b;
    logic [`CORE_REG_ADDR_WIDTH-1:0] rd;      // Zero when nothing is written.
  } alu_req_t;

endpackage : pipe_pkg

`default_nettype wire

// File: source/stage_result_if.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

interface stage_result_if;

  logic                           valid;
  logic                           wr_en;
  logic [`CORE_REG_ADDR_WIDTH-1:0] wr_reg;
  logic [`CORE_DATA_WIDTH-1:0]     result;

  modport producer (output valid, output wr_en, output wr_reg, output result);
  modport consumer (input valid, input wr_en, input wr_reg, input result);

endinterface : stage_result_if

`default_nettype wire

// File: source/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module decode_stage (
  input  logic                         valid_i,
  input  logic                         is_jump_i,
  input  logic                         branch_taken_i,
  input  logic                         stall_i,
  input  isa_pkg::instruction_t        instruction_i,
  input  logic [`CORE_DATA_WIDTH-1:0]  rs1_data_i,
  input  logic [`CORE_DATA_WIDTH-1:0]  rs2_data_i,
  stage_result_if.consumer             mem_res_i,
  stage_result_if.consumer             ex5_res_i,
  stage_result_if.consumer             wb_res_i,
  output logic                         alu_valid_o,
  output logic                         ex_valid_o,
  output logic                         instr_is_wb_o,
  output logic [`CORE_SHAMT_WIDTH-1:0] shamt_o,
  output logic [`CORE_DATA_WIDTH-1:0]  offset_sign_extend_o,
  output pipe_pkg::alu_req_t           alu_req_o,
  output pipe_pkg::hazard_ctrl_t       hazard_signals_o
);

  logic                        executes;
  logic                        valid_instruction;
  isa_pkg::alu_op_e            alu_op;
  logic [`CORE_DATA_WIDTH-1:0] rs1_value;
  logic [`CORE_DATA_WIDTH-1:0] rs2_value;

  // Youngest producer wins.
  function automatic logic [`CORE_DATA_WIDTH-1:0] select_operand(
    input logic [`CORE_REG_ADDR_WIDTH-1:0] src,
    input logic [`CORE_DATA_WIDTH-1:0]     rf_data
  );
    logic [`CORE_DATA_WIDTH-1:0] value;
    value = rf_data;
    if (mem_res_i.valid && mem_res_i.wr_en && mem_res_i.wr_reg == src) begin
      value = mem_res_i.result;
    end else if (ex5_res_i.valid && ex5_res_i.wr_en && ex5_res_i.wr_reg == src) begin
      value = ex5_res_i.result;
    end else if (wb_res_i.valid && wb_res_i.wr_en && wb_res_i.wr_reg == src) begin
      value = wb_res_i.result;
    end
    return value;
  endfunction

  ////////////////////////////////////////////////////////////
  // Register usage
  ////////////////////////////////////////////////////////////

  always_comb begin : register_usage
    hazard_signals_o.rs1        = instruction_i.rs1;
    hazard_signals_o.rs2        = instruction_i.rs2;
    hazard_signals_o.rs1_needed = 1'b0;
    hazard_signals_o.rs2_needed = 1'b0;
    hazard_signals_o.is_mul     = 1'b0;
    instr_is_wb_o               = 1'b0;
    executes                    = 1'b0;
    case (instruction_i.opcode)
      isa_pkg::R: begin
        hazard_signals_o.rs1_needed = 1'b1;
        hazard_signals_o.rs2_needed = 1'b1;
        hazard_signals_o.is_mul     = instruction_i.funct3 == 3'b000 &&
                                      instruction_i.funct7 == 7'b0000001;
        instr_is_wb_o               = 1'b1;
        executes                    = 1'b1;
      end
      isa_pkg::IMMEDIATE: begin
        hazard_signals_o.rs1_needed = 1'b1;
        instr_is_wb_o               = 1'b1;
        executes                    = 1'b1;
      end
      isa_pkg::LOAD: begin
        hazard_signals_o.rs1_needed = 1'b1;
        instr_is_wb_o               = 1'b1;
      end
      isa_pkg::STORE, isa_pkg::BRANCH: begin
        hazard_signals_o.rs1_needed = 1'b1;
        hazard_signals_o.rs2_needed = 1'b1;
      end
      isa_pkg::JAL, isa_pkg::AUIPC: instr_is_wb_o = 1'b1;
      default: ;
    endcase
  end

  always_comb begin : offset_computation
    case (instruction_i.opcode)
      isa_pkg::IMMEDIATE, isa_pkg::LOAD:
        offset_sign_extend_o = {{20{instruction_i[31]}}, instruction_i[31:20]};
      isa_pkg::STORE:
        offset_sign_extend_o = {{20{instruction_i[31]}}, instruction_i[31:25],
                                instruction_i[11:7]};
      isa_pkg::BRANCH:
        offset_sign_extend_o = {{20{instruction_i[31]}}, instruction_i[7],
                                instruction_i[30:25], instruction_i[11:8], 1'b0};
      isa_pkg::JAL:
        offset_sign_extend_o = {{12{instruction_i[31]}}, instruction_i[19:12],
                                instruction_i[20], instruction_i[30:21], 1'b0};
      isa_pkg::AUIPC:
        offset_sign_extend_o = {instruction_i[31:12], 12'b0};
      default:
        offset_sign_extend_o = '0;
    endcase
  end

  assign shamt_o = instruction_i[20 +: `CORE_SHAMT_WIDTH];

  ////////////////////////////////////////////////////////////
  // Operation and operands
  ////////////////////////////////////////////////////////////

  always_comb begin : alu_op_select
    case (instruction_i.funct3)
      3'b000:  alu_op = (instruction_i.opcode == isa_pkg::R && instruction_i.funct7[5]) ?
                        isa_pkg::ALU_SUB : isa_pkg::ALU_ADD;
      3'b111:  alu_op = isa_pkg::ALU_AND;
      3'b110:  alu_op = isa_pkg::ALU_OR;
      3'b100:  alu_op = isa_pkg::ALU_XOR;
      3'b010:  alu_op = isa_pkg::ALU_SLT;
      3'b001:  alu_op = isa_pkg::ALU_SLL;
      3'b101:  alu_op = isa_pkg::ALU_SRL;
      default: alu_op = isa_pkg::ALU_ADD;
    endcase
  end

  always_comb begin : operand_select
    rs1_value = select_operand(instruction_i.rs1, rs1_data_i);
    rs2_value = select_operand(instruction_i.rs2, rs2_data_i);
  end

  always_comb begin : request_build
    alu_req_o.alu_op    = alu_op;
    alu_req_o.operand_a = rs1_value;
    alu_req_o.operand_b = rs2_value;
    alu_req_o.rd        = executes ? instruction_i.rd : '0;  // x0 means no write.
    if (instruction_i.opcode == isa_pkg::IMMEDIATE) begin
      if (alu_op == isa_pkg::ALU_SLL || alu_op == isa_pkg::ALU_SRL) begin
        alu_req_o.operand_b = {{(`CORE_DATA_WIDTH-`CORE_SHAMT_WIDTH){1'b0}}, shamt_o};
      end else begin
        alu_req_o.operand_b = offset_sign_extend_o;
      end
    end
  end

  assign valid_instruction = valid_i & ~stall_i & ~is_jump_i & ~branch_taken_i;
  assign alu_valid_o       = valid_instruction & ~hazard_signals_o.is_mul;
  assign ex_valid_o        = valid_instruction & hazard_signals_o.is_mul;

endmodule : decode_stage

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module register_file (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] rs1_addr_i,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] rs2_addr_i,
  output logic [`CORE_DATA_WIDTH-1:0]     rs1_data_o,
  output logic [`CORE_DATA_WIDTH-1:0]     rs2_data_o,
  stage_result_if.consumer                wb_i
);

  localparam int NUM_REGS = 2 ** `CORE_REG_ADDR_WIDTH;

  logic [`CORE_DATA_WIDTH-1:0] regs_q [NUM_REGS];

  always_ff @(posedge clk_i or negedge arst_n_i) begin : write_port
    if (!arst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wb_i.valid && wb_i.wr_en && wb_i.wr_reg != '0) begin
      regs_q[wb_i.wr_reg] <= wb_i.result;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];  // x0 is hardwired.
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule : register_file

`default_nettype wire

// File: source/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module hazard_unit (
  input  pipe_pkg::hazard_ctrl_t          hazard_signals_i,
  input  logic                            instr_is_wb_i,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] rd_i,
  input  logic                            valid_i,
  input  logic                            alu_stage_valid_i,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] alu_stage_rd_i,
  input  logic [`CORE_MUL_STAGES-2:0]     mul_valid_i,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] mul_rd_i [`CORE_MUL_STAGES-1],
  output logic                            issue_stall_o
);

  always_comb begin : stall_logic
    logic raw_alu;
    logic raw_mul;
    logic waw_mul;
    logic wb_port;
    raw_alu = alu_stage_valid_i &&
              ((hazard_signals_i.rs1_needed && hazard_signals_i.rs1 == alu_stage_rd_i) ||
               (hazard_signals_i.rs2_needed && hazard_signals_i.rs2 == alu_stage_rd_i));
    raw_mul = 1'b0;
    waw_mul = 1'b0;
    for (int i = 0; i < `CORE_MUL_STAGES - 1; i++) begin
      if (mul_valid_i[i]) begin
        raw_mul |= (hazard_signals_i.rs1_needed && hazard_signals_i.rs1 == mul_rd_i[i]) ||
                   (hazard_signals_i.rs2_needed && hazard_signals_i.rs2 == mul_rd_i[i]);
        waw_mul |= instr_is_wb_i && rd_i == mul_rd_i[i];
      end
    end
    wb_port       = !hazard_signals_i.is_mul && mul_valid_i[2];  // MUL in ex3 meets it at wb.
    issue_stall_o = valid_i && (raw_alu || raw_mul || waw_mul || wb_port);
  end

endmodule : hazard_unit

`default_nettype wire

// File: source/alu_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module alu_stage (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            valid_i,
  input  pipe_pkg::alu_req_t              req_i,
  output logic                            stage_valid_o,
  output logic [`CORE_REG_ADDR_WIDTH-1:0] stage_rd_o,
  stage_result_if.producer                mem_res_o
);

  logic                            valid_q;
  pipe_pkg::alu_req_t              req_q;
  logic [`CORE_DATA_WIDTH-1:0]     alu_result;
  logic                            mem_valid_q;
  logic [`CORE_REG_ADDR_WIDTH-1:0] mem_rd_q;
  logic [`CORE_DATA_WIDTH-1:0]     mem_result_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_regs
    if (!arst_n_i) begin
      valid_q     <= 1'b0;
      mem_valid_q <= 1'b0;
    end else begin
      valid_q     <= valid_i;
      mem_valid_q <= valid_q;
    end
  end

  always_ff @(posedge clk_i) begin : payload_regs
    req_q        <= req_i;
    mem_rd_q     <= req_q.rd;
    mem_result_q <= alu_result;
  end

  always_comb begin : compute
    case (req_q.alu_op)
      isa_pkg::ALU_ADD: alu_result = req_q.operand_a + req_q.operand_b;
      isa_pkg::ALU_SUB: alu_result = req_q.operand_a - req_q.operand_b;
      isa_pkg::ALU_AND: alu_result = req_q.operand_a & req_q.operand_b;
      isa_pkg::ALU_OR:  alu_result = req_q.operand_a | req_q.operand_b;
      isa_pkg::ALU_XOR: alu_result = req_q.operand_a ^ req_q.operand_b;
      isa_pkg::ALU_SLT: alu_result = {{(`CORE_DATA_WIDTH-1){1'b0}},
                                      $signed(req_q.operand_a) < $signed(req_q.operand_b)};
      isa_pkg::ALU_SLL: alu_result = req_q.operand_a << req_q.operand_b[`CORE_SHAMT_WIDTH-1:0];
      isa_pkg::ALU_SRL: alu_result = req_q.operand_a >> req_q.operand_b[`CORE_SHAMT_WIDTH-1:0];
      default:          alu_result = '0;
    endcase
  end

  assign stage_valid_o    = valid_q;
  assign stage_rd_o       = req_q.rd;
  assign mem_res_o.valid  = mem_valid_q;
  assign mem_res_o.wr_en  = |mem_rd_q;  // Retired no-ops carry x0.
  assign mem_res_o.wr_reg = mem_rd_q;
  assign mem_res_o.result = mem_result_q;

  mem_result_known: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    mem_valid_q && |mem_rd_q |-> !$isunknown(mem_result_q))
    else $error("Memory stage writes an unknown result.");

endmodule : alu_stage

`default_nettype wire

// File: source/mul_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module mul_pipe (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            valid_i,
  input  logic [`CORE_DATA_WIDTH-1:0]     operand_a_i,
  input  logic [`CORE_DATA_WIDTH-1:0]     operand_b_i,
  input  logic [`CORE_REG_ADDR_WIDTH-1:0] rd_i,
  output logic [`CORE_MUL_STAGES-2:0]     mul_valid_o,
  output logic [`CORE_REG_ADDR_WIDTH-1:0] mul_rd_o [`CORE_MUL_STAGES-1],
  stage_result_if.producer                ex5_res_o
);

  logic [`CORE_MUL_STAGES-1:0]     valid_q;
  logic [`CORE_REG_ADDR_WIDTH-1:0] rd_q [`CORE_MUL_STAGES];
  logic [`CORE_DATA_WIDTH-1:0]     prod_q [`CORE_MUL_STAGES];

  always_ff @(posedge clk_i or negedge arst_n_i) begin : valid_shift
    if (!arst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[`CORE_MUL_STAGES-2:0], valid_i};
    end
  end

  always_ff @(posedge clk_i) begin : payload_shift
    rd_q[0]   <= rd_i;
    prod_q[0] <= operand_a_i * operand_b_i;  // Low half only.
    for (int i = 1; i < `CORE_MUL_STAGES; i++) begin
      rd_q[i]   <= rd_q[i-1];
      prod_q[i] <= prod_q[i-1];
    end
  end

  assign mul_valid_o = valid_q[`CORE_MUL_STAGES-2:0];

  always_comb begin : status_out
    for (int i = 0; i < `CORE_MUL_STAGES - 1; i++) begin
      mul_rd_o[i] = rd_q[i];
    end
  end

  assign ex5_res_o.valid  = valid_q[`CORE_MUL_STAGES-1];
  assign ex5_res_o.wr_en  = 1'b1;
  assign ex5_res_o.wr_reg = rd_q[`CORE_MUL_STAGES-1];
  assign ex5_res_o.result = prod_q[`CORE_MUL_STAGES-1];

endmodule : mul_pipe

`default_nettype wire

// File: source/int_backend_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module int_backend_top (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            instr_valid_i,
  input  logic [31:0]                     instr_i,
  output logic                            issue_stall_o,
  output logic                            wb_valid_o,
  output logic [`CORE_REG_ADDR_WIDTH-1:0] wb_reg_o,
  output logic [`CORE_DATA_WIDTH-1:0]     wb_data_o
);

  isa_pkg::instruction_t           instr;
  pipe_pkg::hazard_ctrl_t          hazard_signals;
  pipe_pkg::alu_req_t              alu_req;
  logic                            alu_valid;
  logic                            ex_valid;
  logic                            instr_is_wb;
  logic [`CORE_DATA_WIDTH-1:0]     rs1_data;
  logic [`CORE_DATA_WIDTH-1:0]     rs2_data;
  logic                            alu_stage_valid;
  logic [`CORE_REG_ADDR_WIDTH-1:0] alu_stage_rd;
  logic [`CORE_MUL_STAGES-2:0]     mul_valid;
  logic [`CORE_REG_ADDR_WIDTH-1:0] mul_rd [`CORE_MUL_STAGES-1];

  stage_result_if mem_res ();
  stage_result_if ex5_res ();
  stage_result_if wb_res ();

  assign instr = isa_pkg::instruction_t'(instr_i);

  decode_stage decode_stage_inst (
    .valid_i              (instr_valid_i),
    .is_jump_i            (1'b0),            // Front end not present.
    .branch_taken_i       (1'b0),
    .stall_i              (issue_stall_o),
    .instruction_i        (instr),
    .rs1_data_i           (rs1_data),
    .rs2_data_i           (rs2_data),
    .mem_res_i            (mem_res.consumer),
    .ex5_res_i            (ex5_res.consumer),
    .wb_res_i             (wb_res.consumer),
    .alu_valid_o          (alu_valid),
    .ex_valid_o           (ex_valid),
    .instr_is_wb_o        (instr_is_wb),
    .shamt_o              (),
    .offset_sign_extend_o (),
    .alu_req_o            (alu_req),
    .hazard_signals_o     (hazard_signals)
  );

  register_file register_file_inst (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .rs1_addr_i (instr.rs1),
    .rs2_addr_i (instr.rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_i       (wb_res.consumer)
  );

  hazard_unit hazard_unit_inst (
    .hazard_signals_i  (hazard_signals),
    .instr_is_wb_i     (instr_is_wb),
    .rd_i              (instr.rd),
    .valid_i           (instr_valid_i),
    .alu_stage_valid_i (alu_stage_valid),
    .alu_stage_rd_i    (alu_stage_rd),
    .mul_valid_i       (mul_valid),
    .mul_rd_i          (mul_rd),
    .issue_stall_o     (issue_stall_o)
  );

  alu_stage alu_stage_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .valid_i       (alu_valid),
    .req_i         (alu_req),
    .stage_valid_o (alu_stage_valid),
    .stage_rd_o    (alu_stage_rd),
    .mem_res_o     (mem_res.producer)
  );

  mul_pipe mul_pipe_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .valid_i     (ex_valid),
    .operand_a_i (alu_req.operand_a),
    .operand_b_i (alu_req.operand_b),
    .rd_i        (alu_req.rd),
    .mul_valid_o (mul_valid),
    .mul_rd_o    (mul_rd),
    .ex5_res_o   (ex5_res.producer)
  );

  ////////////////////////////////////////////////////////////
  // Writeback register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin : wb_valid_reg
    if (!arst_n_i) begin
      wb_res.valid <= 1'b0;
    end else begin
      wb_res.valid <= mem_res.valid | ex5_res.valid;
    end
  end

  always_ff @(posedge clk_i) begin : wb_payload_reg
    if (ex5_res.valid) begin
      wb_res.wr_en  <= ex5_res.wr_en;
      wb_res.wr_reg <= ex5_res.wr_reg;
      wb_res.result <= ex5_res.result;
    end else begin
      wb_res.wr_en  <= mem_res.wr_en;
      wb_res.wr_reg <= mem_res.wr_reg;
      wb_res.result <= mem_res.result;
    end
  end

  assign wb_valid_o = wb_res.valid & wb_res.wr_en;  // No-ops retire silently.
  assign wb_reg_o   = wb_res.wr_reg;
  assign wb_data_o  = wb_res.result;

  single_wb_source: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(mem_res.valid && ex5_res.valid))
    else $error("Memory stage and multiply stage 5 valid in the same cycle.");

endmodule : int_backend_top

`default_nettype wire

// File: bench/int_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "core_defines.svh"

module int_backend_tb;

  localparam int SEED           = 85304;
  localparam int NUM_INSTR      = 400;
  localparam int TIMEOUT_CYCLES = NUM_INSTR * 8 + 100;
  localparam int DRIVE_DELAY    = 1;
  localparam int ALU_LATENCY    = 3;
  localparam int MUL_LATENCY    = 6;

  typedef struct packed {
    logic [`CORE_REG_ADDR_WIDTH-1:0] rd;
    logic [`CORE_DATA_WIDTH-1:0]     data;
    logic [31:0]                     due;
  } expect_t;

  logic                            clk_i;
  logic                            arst_n_i;
  logic                            instr_valid_i;
  logic [31:0]                     instr_i;
  logic                            issue_stall_o;
  logic                            wb_valid_o;
  logic [`CORE_REG_ADDR_WIDTH-1:0] wb_reg_o;
  logic [`CORE_DATA_WIDTH-1:0]     wb_data_o;

  int                              cycle_count = 0;
  int                              error_count = 0;
  int                              wb_checked  = 0;
  int                              mul_count   = 0;
  int                              noop_count  = 0;
  logic                            accepted    = 1'b0;
  logic [`CORE_DATA_WIDTH-1:0]     model_regs [32];
  logic [`CORE_REG_ADDR_WIDTH-1:0] recent_rd [3];
  expect_t                         expected_q [$];

  int_backend_top int_backend_top_inst (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .issue_stall_o (issue_stall_o),
    .wb_valid_o    (wb_valid_o),
    .wb_reg_o      (wb_reg_o),
    .wb_data_o     (wb_data_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin : cycle_counter
    cycle_count <= cycle_count + 1;
  end

  ////////////////////////////////////////////////////////////
  // Checks and reference model
  ////////////////////////////////////////////////////////////

  task automatic check_wb_reg(input logic [`CORE_REG_ADDR_WIDTH-1:0] expected,
                              input logic [`CORE_REG_ADDR_WIDTH-1:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch wb_reg_o at cycle %0d: expected 0x%h, got 0x%h",
               cycle_count, expected, actual);
    end
  endtask

  task automatic check_wb_data(input logic [`CORE_DATA_WIDTH-1:0] expected,
                               input logic [`CORE_DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      error_count++;
      $display("mismatch wb_data_o at cycle %0d: expected 0x%h, got 0x%h",
               cycle_count, expected, actual);
    end
  endtask

  // RV32 semantics for the supported subset.
  function automatic logic [`CORE_DATA_WIDTH-1:0] expected_result(
    input isa_pkg::instruction_t       ins,
    input logic [`CORE_DATA_WIDTH-1:0] a,
    input logic [`CORE_DATA_WIDTH-1:0] b
  );
    logic [`CORE_DATA_WIDTH-1:0] imm;
    logic [`CORE_DATA_WIDTH-1:0] opb;
    logic [4:0]                  shamt;
    imm   = {{20{ins.funct7[6]}}, ins.funct7, ins.rs2};
    opb   = (ins.opcode == isa_pkg::IMMEDIATE) ? imm : b;
    shamt = (ins.opcode == isa_pkg::IMMEDIATE) ? ins.rs2 : b[4:0];
    case (ins.funct3)
      3'b000: begin
        if (ins.opcode == isa_pkg::R && ins.funct7 == 7'b0000001) begin
          return a * b;  // Low 32 bits.
        end else if (ins.opcode == isa_pkg::R && ins.funct7 == 7'b0100000) begin
          return a - b;
        end
        return a + opb;
      end
      3'b111:  return a & opb;
      3'b110:  return a | opb;
      3'b100:  return a ^ opb;
      3'b010:  return ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
      3'b001:  return a << shamt;
      3'b101:  return a >> shamt;
      default: return '0;
    endcase
  endfunction

  always @(negedge clk_i) begin : monitor
    int                          found;
    isa_pkg::instruction_t       ins;
    logic [`CORE_DATA_WIDTH-1:0] result;
    expect_t                     entry;
    found = -1;
    foreach (expected_q[i]) begin
      if (expected_q[i].due == cycle_count) begin
        found = i;
      end
    end
    if (wb_valid_o) begin
      if (found < 0) begin
        error_count++;
        $display("Unexpected writeback to x%0d at cycle %0d with nothing due.",
                 wb_reg_o, cycle_count);
      end else begin
        check_wb_reg(expected_q[found].rd, wb_reg_o);
        check_wb_data(expected_q[found].data, wb_data_o);
        wb_checked++;
        expected_q.delete(found);
      end
    end else if (found >= 0) begin
      error_count++;
      $display("Writeback to x%0d due at cycle %0d did not appear.",
               expected_q[found].rd, cycle_count);
      expected_q.delete(found);
    end
    if (issue_stall_o && !instr_valid_i) begin
      error_count++;
      $display("Issue stall raised at cycle %0d with no instruction offered.", cycle_count);
    end
    accepted = instr_valid_i && !issue_stall_o;  // Taken on the next rising edge.
    if (accepted) begin
      ins = isa_pkg::instruction_t'(instr_i);
      if (ins.opcode == isa_pkg::R || ins.opcode == isa_pkg::IMMEDIATE) begin
        result     = expected_result(ins, model_regs[ins.rs1], model_regs[ins.rs2]);
        entry.rd   = ins.rd;
        entry.data = result;
        if (ins.opcode == isa_pkg::R && ins.funct3 == 3'b000 && ins.funct7 == 7'b0000001) begin
          entry.due = cycle_count + MUL_LATENCY;
          mul_count++;
        end else begin
          entry.due = cycle_count + ALU_LATENCY;
        end
        expected_q.push_back(entry);
        model_regs[ins.rd] = result;
      end else begin
        noop_count++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Half the sources reuse a recent destination.
  function automatic logic [4:0] pick_source();
    if ($urandom_range(0, 1) == 0) begin
      return recent_rd[$urandom_range(0, 2)];
    end
    return 5'($urandom_range(1, 31));
  endfunction

  function automatic logic [31:0] make_instruction();
    isa_pkg::instruction_t ins;
    logic [31:0]           word;
    int                    kind;
    int                    op;
    kind = $urandom_range(0, 99);
    if (kind >= 80) begin
      word = $urandom();
      case ($urandom_range(0, 2))
        0:       word[6:0] = isa_pkg::LOAD;
        1:       word[6:0] = isa_pkg::STORE;
        default: word[6:0] = isa_pkg::BRANCH;
      endcase
      return word;
    end
    ins.rd  = 5'($urandom_range(1, 31));
    ins.rs1 = pick_source();
    if (kind < 40) begin
      ins.opcode = isa_pkg::R;
      ins.rs2    = pick_source();
      ins.funct7 = 7'b0000000;
      op         = $urandom_range(0, 8);
      case (op)
        0:       ins.funct3 = 3'b000;
        1: begin
          ins.funct3 = 3'b000;
          ins.funct7 = 7'b0100000;  // SUB.
        end
        2:       ins.funct3 = 3'b111;
        3:       ins.funct3 = 3'b110;
        4:       ins.funct3 = 3'b100;
        5:       ins.funct3 = 3'b010;
        6:       ins.funct3 = 3'b001;
        7:       ins.funct3 = 3'b101;
        default: begin
          ins.funct3 = 3'b000;
          ins.funct7 = 7'b0000001;  // MUL.
        end
      endcase
    end else begin
      ins.opcode = isa_pkg::IMMEDIATE;
      {ins.funct7, ins.rs2} = 12'($urandom());
      case ($urandom_range(0, 5))
        0:       ins.funct3 = 3'b000;
        1:       ins.funct3 = 3'b111;
        2:       ins.funct3 = 3'b110;
        3:       ins.funct3 = 3'b100;
        4:       ins.funct3 = 3'b001;
        default: ins.funct3 = 3'b101;
      endcase
      if (ins.funct3 == 3'b001 || ins.funct3 == 3'b101) begin
        ins.funct7 = 7'b0000000;
      end
    end
    recent_rd[2] = recent_rd[1];
    recent_rd[1] = recent_rd[0];
    recent_rd[0] = ins.rd;
    return ins;
  endfunction

  initial begin : watchdog
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles with %0d errors so far.", TIMEOUT_CYCLES, error_count);
    $display("Errors found");
    $finish;
  end

  initial begin : driver
    int sent;
    arst_n_i      = 1'b0;
    instr_valid_i = 1'b0;
    instr_i       = '0;
    sent          = 0;
    void'($urandom(SEED));
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    recent_rd[0] = 5'd1;
    recent_rd[1] = 5'd2;
    recent_rd[2] = 5'd3;
    repeat (3) @(posedge clk_i);
    #DRIVE_DELAY;
    arst_n_i = 1'b1;
    repeat (4) @(posedge clk_i);  // Idle cycles, outputs must stay low.
    while (sent < NUM_INSTR) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (instr_valid_i && accepted) begin
        sent++;
        instr_valid_i = 1'b0;
      end
      if (sent < NUM_INSTR && !instr_valid_i && $urandom_range(0, 3) != 0) begin
        instr_i       = make_instruction();
        instr_valid_i = 1'b1;
      end
    end
    repeat (MUL_LATENCY + 4) @(posedge clk_i);
    if (expected_q.size() != 0) begin
      error_count++;
      $display("%0d expected writebacks never appeared.", expected_q.size());
    end
    $display("Run done: %0d instructions, %0d MUL, %0d no-ops, %0d writebacks, %0d errors",
             sent, mul_count, noop_count, wb_checked, error_count);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule : int_backend_tb

`default_nettype wire

// File: flist.f
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/stage_result_if.sv
source/decode_stage.sv
source/register_file.sv
source/hazard_unit.sv
source/alu_stage.sv
source/mul_pipe.sv
source/int_backend_top.sv
bench/int_backend_tb.sv
